/* design/alu_adder.sv */
`timescale 1ns/1ps

module alu_adder import alu_pkg::*; (
  input  alu_req_t          req_i,
  output logic [DATA_W-1:0] adder_result_o
);

  // one carry control bit in front of every byte
  localparam int ADD_W = DATA_W + NUM_LANES;

  logic              negate;
  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;
  logic [NUM_LANES-1:0] lane_start;
  logic [ADD_W-1:0]  in_a;
  logic [ADD_W-1:0]  in_b;
  logic [ADD_W-1:0]  sum;

  // sub negates b, abs negates a, both need the +1
  assign negate = (req_i.operator == ALU_SUB) || (req_i.operator == ALU_ABS);

  assign op_a = (req_i.operator == ALU_ABS) ? ~req_i.operand_a : req_i.operand_a;
  assign op_b = (req_i.operator == ALU_SUB) ? ~req_i.operand_b : req_i.operand_b;

  // bytes that begin a new lane, byte 0 always does
  always_comb begin
    case (req_i.vec_mode)
      VEC_MODE8:  lane_start = 4'b1111;
      VEC_MODE16: lane_start = 4'b0101;
      default:    lane_start = 4'b0001;
    endcase
  end

  // control bit pairs (a,b):
  //   1,0 passes the carry of the byte below
  //   0,0 blocks it at a lane start
  //   1,1 injects the +1 of a negation
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      in_a[(LANE_W+1)*i] = ~lane_start[i] | negate;
      in_b[(LANE_W+1)*i] = lane_start[i] & negate;
      in_a[(LANE_W+1)*i+1 +: LANE_W] = op_a[LANE_W*i +: LANE_W];
      in_b[(LANE_W+1)*i+1 +: LANE_W] = op_b[LANE_W*i +: LANE_W];
    end
  end

  assign sum = in_a + in_b;

  // drop the control positions again
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      adder_result_o[LANE_W*i +: LANE_W] = sum[(LANE_W+1)*i+1 +: LANE_W];
    end
  end

endmodule

/* design/alu_bitcount.sv */
`timescale 1ns/1ps

module alu_bitcount import alu_pkg::*; (
  input  alu_req_t         req_i,
  output logic [CNT_W-1:0] bitop_result_o
);

  localparam int IDX_W = $clog2(DATA_W);

  logic [NUM_LANES-1:0][3:0] byte_cnt;
  logic [1:0][4:0]           half_cnt;
  logic [CNT_W-1:0]          cnt_result;
  logic [DATA_W-1:0]         a_rev;
  logic [DATA_W-1:0]         ff_input;
  logic [IDX_W-1:0]          ff_index;
  logic                      ff_no_one;

  ////////////////////////////////////////
  // population count
  ////////////////////////////////////////

  // per byte sums first then a small adder tree
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      byte_cnt[i] = '0;
      for (int b = 0; b < LANE_W; b++) begin
        byte_cnt[i] = byte_cnt[i] + 4'(req_i.operand_a[LANE_W*i+b]);
      end
    end
  end

  assign half_cnt[0] = 5'(byte_cnt[0]) + 5'(byte_cnt[1]);
  assign half_cnt[1] = 5'(byte_cnt[2]) + 5'(byte_cnt[3]);
  assign cnt_result  = CNT_W'(half_cnt[0]) + CNT_W'(half_cnt[1]);

  ////////////////////////////////////////
  // find first one
  ////////////////////////////////////////

  assign a_rev = {<<{req_i.operand_a}};

  // on the reversed word the lowest index counts down from the msb
  always_comb begin
    case (req_i.operator)
      ALU_FL1: ff_input = a_rev;
      ALU_CLB: ff_input = req_i.operand_a[DATA_W-1] ? ~a_rev : a_rev;
      default: ff_input = req_i.operand_a;
    endcase
  end

  alu_find_first #(
    .LEN (DATA_W)
  ) alu_find_first_inst (
    .in_i        (ff_input),
    .first_one_o (ff_index),
    .no_ones_o   (ff_no_one)
  );

  always_comb begin
    case (req_i.operator)
      // fl1 already sees 31 minus the top index through the reversal
      ALU_FF1, ALU_FL1: bitop_result_o = ff_no_one ? CNT_W'(DATA_W) : CNT_W'(ff_index);
      ALU_CNT: bitop_result_o = cnt_result;
      ALU_CLB: begin
        // no hit means all bits equal the sign
        if (ff_no_one)
          bitop_result_o = req_i.operand_a[DATA_W-1] ? CNT_W'(DATA_W - 1) : '0;
        else
          bitop_result_o = CNT_W'(ff_index) - CNT_W'(1);
      end
      default: bitop_result_o = '0;
    endcase
  end

endmodule

/* design/alu_compare.sv */
`timescale 1ns/1ps

module alu_compare import alu_pkg::*; (
  input  alu_req_t          req_i,
  input  logic [DATA_W-1:0] adder_result_i,
  output lane_mask_t        cmp_lanes_o,
  output logic              cmp_flag_o,
  output logic [DATA_W-1:0] minmax_result_o
);

  logic              signed_op;
  logic              do_min;
  lane_mask_t        cmp_signed;
  lane_mask_t        eq_byte;
  lane_mask_t        gt_byte;
  lane_mask_t        is_equal;
  lane_mask_t        is_greater;
  lane_mask_t        sel_a;
  logic [DATA_W-1:0] minmax_b;

  always_comb begin
    case (req_i.operator)
      ALU_GTS, ALU_GES, ALU_LTS, ALU_LES, ALU_SLTS, ALU_MIN, ALU_MAX, ALU_ABS:
        signed_op = 1'b1;
      default:
        signed_op = 1'b0;
    endcase
  end

  // sign is only taken from the top byte of each lane
  always_comb begin
    case (req_i.vec_mode)
      VEC_MODE8:  cmp_signed = {NUM_LANES{signed_op}};
      VEC_MODE16: cmp_signed = {signed_op, 1'b0, signed_op, 1'b0};
      default:    cmp_signed = {signed_op, 3'b000};
    endcase
  end

  ////////////////////////////////////////
  // byte compare, merged per lane
  ////////////////////////////////////////

  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_byte_cmp
    assign eq_byte[i] = (req_i.operand_a[LANE_W*i +: LANE_W] ==
                         req_i.operand_b[LANE_W*i +: LANE_W]);
    // extra top bit is the sign when signed, else zero
    assign gt_byte[i] =
      $signed({req_i.operand_a[LANE_W*i+LANE_W-1] & cmp_signed[i],
               req_i.operand_a[LANE_W*i +: LANE_W]}) >
      $signed({req_i.operand_b[LANE_W*i+LANE_W-1] & cmp_signed[i],
               req_i.operand_b[LANE_W*i +: LANE_W]});
  end

  always_comb begin
    case (req_i.vec_mode)
      VEC_MODE8: begin
        is_equal   = eq_byte;
        is_greater = gt_byte;
      end
      VEC_MODE16: begin
        is_equal   = {{2{eq_byte[3] & eq_byte[2]}}, {2{eq_byte[1] & eq_byte[0]}}};
        is_greater = {{2{gt_byte[3] | (eq_byte[3] & gt_byte[2])}},
                      {2{gt_byte[1] | (eq_byte[1] & gt_byte[0])}}};
      end
      default: begin
        is_equal   = {NUM_LANES{&eq_byte}};
        // upper byte decides unless equal
        is_greater = {NUM_LANES{gt_byte[3] | (eq_byte[3] & (gt_byte[2] |
                     (eq_byte[2] & (gt_byte[1] | (eq_byte[1] & gt_byte[0])))))}};
      end
    endcase
  end

  always_comb begin
    case (req_i.operator)
      ALU_EQ:                     cmp_lanes_o = is_equal;
      ALU_NE:                     cmp_lanes_o = ~is_equal;
      ALU_GTS, ALU_GTU:           cmp_lanes_o = is_greater;
      ALU_GES, ALU_GEU:           cmp_lanes_o = is_greater | is_equal;
      ALU_LTS, ALU_LTU,
      ALU_SLTS, ALU_SLTU:         cmp_lanes_o = ~(is_greater | is_equal);
      ALU_LES, ALU_LEU:           cmp_lanes_o = ~is_greater;
      default:                    cmp_lanes_o = '0;
    endcase
  end

  // top byte always belongs to the top lane
  assign cmp_flag_o = cmp_lanes_o[NUM_LANES-1];

  ////////////////////////////////////////
  // min, max and abs select
  ////////////////////////////////////////

  // for abs b is zero, so a > 0 keeps a and the rest takes -a
  assign minmax_b = (req_i.operator == ALU_ABS) ? adder_result_i : req_i.operand_b;
  assign do_min   = (req_i.operator == ALU_MIN) || (req_i.operator == ALU_MINU);
  assign sel_a    = is_greater ^ {NUM_LANES{do_min}};

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      minmax_result_o[LANE_W*i +: LANE_W] = sel_a[i] ? req_i.operand_a[LANE_W*i +: LANE_W] :
                                                       minmax_b[LANE_W*i +: LANE_W];
    end
  end

endmodule

/* design/alu_find_first.sv */
`timescale 1ns/1ps

module alu_find_first #(
  parameter int LEN = 32
) (
  input  logic [LEN-1:0]         in_i,
  output logic [$clog2(LEN)-1:0] first_one_o,
  output logic                   no_ones_o
);

  localparam int NUM_LEVELS = $clog2(LEN);
  // tree works on a power of two, unused leaves read zero
  localparam int PAD_LEN    = 2 ** NUM_LEVELS;

  logic [PAD_LEN-1:0]                  in_pad;
  // heap order, node k has children 2k+1 and 2k+2
  logic [PAD_LEN-2:0]                  sel_nodes;
  logic [PAD_LEN-2:0][NUM_LEVELS-1:0]  idx_nodes;

  assign in_pad = PAD_LEN'(in_i);

  for (genvar lvl = 0; lvl < NUM_LEVELS; lvl++) begin : gen_level
    for (genvar n = 0; n < 2 ** lvl; n++) begin : gen_node
      localparam int NODE = 2 ** lvl - 1 + n;
      if (lvl == NUM_LEVELS - 1) begin : gen_leaf
        // leaf n looks at bits 2n and 2n+1, lower one wins
        assign sel_nodes[NODE] = in_pad[2*n] | in_pad[2*n+1];
        assign idx_nodes[NODE] = in_pad[2*n] ? NUM_LEVELS'(2*n) : NUM_LEVELS'(2*n+1);
      end else begin : gen_inner
        localparam int LEFT = 2 * NODE + 1;
        // left child covers the lower indices
        assign sel_nodes[NODE] = sel_nodes[LEFT] | sel_nodes[LEFT+1];
        assign idx_nodes[NODE] = sel_nodes[LEFT] ? idx_nodes[LEFT] : idx_nodes[LEFT+1];
      end
    end
  end

  // root carries the result
  assign first_one_o = idx_nodes[0];
  assign no_ones_o   = ~sel_nodes[0];

endmodule

/* design/alu_pkg.sv */
package alu_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int DATA_W    = 32;
  localparam int LANE_W    = 8;
  localparam int NUM_LANES = DATA_W / LANE_W;
  // enough bits to hold the value 32
  localparam int CNT_W     = 6;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  typedef enum logic [4:0] {
    ALU_ADD  = 5'h00, ALU_SUB  = 5'h01, ALU_ABS  = 5'h02,
    ALU_AND  = 5'h03, ALU_OR   = 5'h04, ALU_XOR  = 5'h05,
    ALU_SLL  = 5'h06, ALU_SRL  = 5'h07, ALU_SRA  = 5'h08,
    ALU_ROR  = 5'h09, ALU_EQ   = 5'h0a, ALU_NE   = 5'h0b,
    ALU_GTS  = 5'h0c, ALU_GTU  = 5'h0d, ALU_GES  = 5'h0e,
    ALU_GEU  = 5'h0f, ALU_LTS  = 5'h10, ALU_LTU  = 5'h11,
    ALU_LES  = 5'h12, ALU_LEU  = 5'h13, ALU_SLTS = 5'h14,
    ALU_SLTU = 5'h15, ALU_MIN  = 5'h16, ALU_MINU = 5'h17,
    ALU_MAX  = 5'h18, ALU_MAXU = 5'h19, ALU_FF1  = 5'h1a,
    ALU_FL1  = 5'h1b, ALU_CNT  = 5'h1c, ALU_CLB  = 5'h1d
  } alu_op_e;

  // same lane mode encoding as the core decoder
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  // one bit per byte lane
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  typedef struct packed {
    alu_op_e           operator;
    vec_mode_e         vec_mode;
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;
  } alu_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] result;
    logic              cmp_flag;
  } alu_rsp_t;

endpackage

/* design/alu_result_stage.sv */
`timescale 1ns/1ps

module alu_result_stage import alu_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  alu_req_t          req_i,
  input  logic [DATA_W-1:0] adder_result_i,
  input  logic [DATA_W-1:0] shift_result_i,
  input  lane_mask_t        cmp_lanes_i,
  input  logic              cmp_flag_i,
  input  logic [DATA_W-1:0] minmax_result_i,
  input  logic [CNT_W-1:0]  bitop_result_i,
  output logic              valid_o,
  output alu_rsp_t          rsp_o
);

  alu_rsp_t rsp_d;

  ////////////////////////////////////////
  // result mux
  ////////////////////////////////////////

  always_comb begin
    rsp_d          = '0;
    rsp_d.cmp_flag = cmp_flag_i;
    case (req_i.operator)
      ALU_ADD, ALU_SUB:  rsp_d.result = adder_result_i;
      ALU_AND:           rsp_d.result = req_i.operand_a & req_i.operand_b;
      ALU_OR:            rsp_d.result = req_i.operand_a | req_i.operand_b;
      ALU_XOR:           rsp_d.result = req_i.operand_a ^ req_i.operand_b;
      ALU_SLL, ALU_SRL,
      ALU_SRA, ALU_ROR:  rsp_d.result = shift_result_i;
      ALU_MIN, ALU_MINU,
      ALU_MAX, ALU_MAXU,
      ALU_ABS:           rsp_d.result = minmax_result_i;
      ALU_EQ, ALU_NE,
      ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU,
      ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU: begin
        // each byte flag fills its own byte
        for (int i = 0; i < NUM_LANES; i++) begin
          rsp_d.result[LANE_W*i +: LANE_W] = {LANE_W{cmp_lanes_i[i]}};
        end
      end
      // set-less-than gives a plain 0 or 1
      ALU_SLTS, ALU_SLTU: rsp_d.result = DATA_W'(cmp_flag_i);
      ALU_FF1, ALU_FL1,
      ALU_CNT, ALU_CLB:   rsp_d.result = DATA_W'(bitop_result_i);
      default:            rsp_d.result = '0;
    endcase
  end

  ////////////////////////////////////////
  // execute stage register
  ////////////////////////////////////////

  // response holds its value through idle cycles
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
      rsp_o   <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        rsp_o <= rsp_d;
      end
    end
  end

endmodule

/* design/alu_shifter.sv */
`timescale 1ns/1ps

module alu_shifter import alu_pkg::*; (
  input  alu_req_t          req_i,
  output logic [DATA_W-1:0] shift_result_o
);

  logic                shift_left;
  logic                shift_arith;
  logic [DATA_W-1:0]   shift_op_a;
  logic [DATA_W-1:0]   shift_amt;
  logic [DATA_W-1:0]   right_result;
  logic [2*DATA_W-1:0] rot_pair;

  assign shift_left  = (req_i.operator == ALU_SLL);
  assign shift_arith = (req_i.operator == ALU_SRA);

  ////////////////////////////////////////
  // operand preparation
  ////////////////////////////////////////

  // left shift is a right shift of the bit reversed word
  assign shift_op_a = shift_left ? {<<{req_i.operand_a}} : req_i.operand_a;

  // reversing the bits also swaps the lanes, so the amounts follow
  always_comb begin
    shift_amt = req_i.operand_b;
    if (shift_left) begin
      case (req_i.vec_mode)
        VEC_MODE16: shift_amt = {<<16{req_i.operand_b}};
        VEC_MODE8:  shift_amt = {<<8{req_i.operand_b}};
        default:    shift_amt = req_i.operand_b;
      endcase
    end
  end

  // doubled word, the low half holds the rotate
  assign rot_pair = {shift_op_a, shift_op_a} >> shift_amt[4:0];

  ////////////////////////////////////////
  // lane wise right shift
  ////////////////////////////////////////

  always_comb begin
    right_result = '0;
    case (req_i.vec_mode)
      VEC_MODE16: begin
        for (int h = 0; h < 2; h++) begin
          if (shift_arith)
            right_result[16*h +: 16] =
              $unsigned($signed(shift_op_a[16*h +: 16]) >>> shift_amt[16*h +: 4]);
          else
            right_result[16*h +: 16] = shift_op_a[16*h +: 16] >> shift_amt[16*h +: 4];
        end
      end
      VEC_MODE8: begin
        for (int b = 0; b < NUM_LANES; b++) begin
          if (shift_arith)
            right_result[LANE_W*b +: LANE_W] =
              $unsigned($signed(shift_op_a[LANE_W*b +: LANE_W]) >>> shift_amt[LANE_W*b +: 3]);
          else
            right_result[LANE_W*b +: LANE_W] =
              shift_op_a[LANE_W*b +: LANE_W] >> shift_amt[LANE_W*b +: 3];
        end
      end
      default: begin
        // ror only rotates here, in vector modes it falls through as srl
        if (shift_arith)
          right_result = $unsigned($signed(shift_op_a) >>> shift_amt[4:0]);
        else if (req_i.operator == ALU_ROR)
          right_result = rot_pair[DATA_W-1:0];
        else
          right_result = shift_op_a >> shift_amt[4:0];
      end
    endcase
  end

  // undo the bit reversal for left shifts
  assign shift_result_o = shift_left ? {<<{right_result}} : right_result;

endmodule

/* design/alu_top.sv */
`timescale 1ns/1ps

module alu_top import alu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  alu_req_t req_i,
  output logic     valid_o,
  output alu_rsp_t rsp_o
);

  // datapath results of the combinational units
  logic [DATA_W-1:0] adder_result;
  logic [DATA_W-1:0] shift_result;
  logic [DATA_W-1:0] minmax_result;
  lane_mask_t        cmp_lanes;
  logic              cmp_flag;
  logic [CNT_W-1:0]  bitop_result;

  alu_adder alu_adder_inst (
    .req_i          (req_i),
    .adder_result_o (adder_result)
  );

  alu_shifter alu_shifter_inst (
    .req_i          (req_i),
    .shift_result_o (shift_result)
  );

  // abs reuses the adder's negated operand a
  alu_compare alu_compare_inst (
    .req_i           (req_i),
    .adder_result_i  (adder_result),
    .cmp_lanes_o     (cmp_lanes),
    .cmp_flag_o      (cmp_flag),
    .minmax_result_o (minmax_result)
  );

  alu_bitcount alu_bitcount_inst (
    .req_i          (req_i),
    .bitop_result_o (bitop_result)
  );

  // final mux plus the execute stage register
  alu_result_stage alu_result_stage_inst (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .valid_i         (valid_i),
    .req_i           (req_i),
    .adder_result_i  (adder_result),
    .shift_result_i  (shift_result),
    .cmp_lanes_i     (cmp_lanes),
    .cmp_flag_i      (cmp_flag),
    .minmax_result_i (minmax_result),
    .bitop_result_i  (bitop_result),
    .valid_o         (valid_o),
    .rsp_o           (rsp_o)
  );

endmodule

/* dv/alu_tb.sv */
`timescale 1ns/1ps

module alu_tb import alu_pkg::*; ();

  localparam int CLK_PERIOD    = 4;
  localparam int WORDS_PER_VEC = 7;
  localparam int MAX_VEC       = 64;

  // one expected entry per driven cycle
  typedef struct packed {
    logic     valid;
    alu_rsp_t rsp;
  } expect_t;

  logic     clk = 1'b0;
  logic     rst_n_i;
  logic     valid_i;
  alu_req_t req_i;
  logic     valid_o;
  alu_rsp_t rsp_o;

  // flat word image of the vector file with seven words per row
  logic [31:0] vec_mem [WORDS_PER_VEC*MAX_VEC];
  int          num_vec     = 0;
  int          error_count = 0;
  int          check_count = 0;
  logic        loaded      = 1'b0;

  // stimulus side state that changes together with the DUT inputs
  logic        driving;
  expect_t     cur_exp;
  // checker side
  expect_t     exp_q[$];
  alu_rsp_t    held_rsp = '0;

  always #(CLK_PERIOD/2) clk = ~clk;

  alu_top alu_top_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .req_i   (req_i),
    .valid_o (valid_o),
    .rsp_o   (rsp_o)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      $display("Fail %s: expected 0x%08h, got 0x%08h at %0t", name, expected, actual, $time);
      error_count++;
    end
  endtask

  task automatic load_vectors();
    // fill first so rows past the end of the file stand out
    for (int k = 0; k < WORDS_PER_VEC*MAX_VEC; k++) begin
      vec_mem[k] = ~32'(k);
    end
    $readmemh("dv/alu_testdata.txt", vec_mem);
    // the valid column only ever holds 0 or 1
    while (num_vec < MAX_VEC && vec_mem[WORDS_PER_VEC*num_vec] <= 32'd1) begin
      num_vec++;
    end
  endtask

  task automatic drive_vector(input int idx);
    int      base;
    expect_t item;
    base              = WORDS_PER_VEC * idx;
    item.valid        = vec_mem[base][0];
    item.rsp.result   = vec_mem[base+5];
    item.rsp.cmp_flag = vec_mem[base+6][0];
    valid_i         <= vec_mem[base][0];
    req_i.operator  <= alu_op_e'(vec_mem[base+1][4:0]);
    req_i.vec_mode  <= vec_mode_e'(vec_mem[base+2][1:0]);
    req_i.operand_a <= vec_mem[base+3];
    req_i.operand_b <= vec_mem[base+4];
    cur_exp         <= item;
  endtask

  ////////////////////////////////////////
  // response checker on the falling edge
  ////////////////////////////////////////

  always @(negedge clk) begin
    expect_t item;
    if (!rst_n_i) begin
      compare_word("valid_o", 32'h0, 32'(valid_o));
      compare_word("rsp_o.result", 32'h0, rsp_o.result);
      compare_word("rsp_o.cmp_flag", 32'h0, 32'(rsp_o.cmp_flag));
    end else begin
      if (exp_q.size() != 0 && exp_q[0].valid) begin
        // entry went into the register at the last rising edge
        item = exp_q.pop_front();
        check_count++;
        if (valid_o !== 1'b1) begin
          $display("valid_o stayed low one cycle after a driven vector at %0t", $time);
          error_count++;
        end
        compare_word("rsp_o.result", item.rsp.result, rsp_o.result);
        compare_word("rsp_o.cmp_flag", 32'(item.rsp.cmp_flag), 32'(rsp_o.cmp_flag));
        held_rsp = item.rsp;
      end else begin
        // on an idle cycle or with nothing in flight the register holds
        if (exp_q.size() != 0) begin
          item = exp_q.pop_front();
        end
        check_count++;
        if (valid_o !== 1'b0) begin
          $display("valid_o went high without a request at %0t", $time);
          error_count++;
        end
        compare_word("rsp_o.result", held_rsp.result, rsp_o.result);
        compare_word("rsp_o.cmp_flag", 32'(held_rsp.cmp_flag), 32'(rsp_o.cmp_flag));
      end
      if (driving) begin
        exp_q.push_back(cur_exp);
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    rst_n_i = 1'b0;
    valid_i = 1'b0;
    req_i   = '0;
    driving = 1'b0;
    cur_exp = '0;
    load_vectors();
    loaded = 1'b1;
    if (num_vec == 0) begin
      $display("no vectors were read from the data file");
      error_count++;
    end
    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;
    @(posedge clk);
    // one row per cycle back to back with the idle rows in between
    for (int i = 0; i < num_vec; i++) begin
      drive_vector(i);
      driving <= 1'b1;
      @(posedge clk);
    end
    valid_i <= 1'b0;
    driving <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    $display("vectors: %0d, checks: %0d, errors: %0d", num_vec, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog sized from the vector count
  initial begin
    wait (loaded);
    #(CLK_PERIOD * (num_vec + 20));
    $display("watchdog expired before all vectors were checked");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* dv/alu_testdata.txt */
// valid operator vec_mode operand_a operand_b result cmp_flag, all hex
// vec_mode 0 is 32-bit, 2 is 16-bit, 3 is 8-bit; rows with valid 0 are idle cycles
1 00 3 ffffffff 01010101 00000000 0
1 00 0 0000ffff 00000001 00010000 0
1 01 3 00010203 01010101 ff000102 0
1 01 2 00000000 00010001 ffffffff 0
0 00 0 00000000 00000000 00000000 0
1 02 3 80fe0105 00000000 80020105 0
1 03 0 f0f0ff00 ff00f0f0 f000f000 0
1 04 0 f0f0ff00 0f0f000f ffffff0f 0
1 05 0 12345678 ffffffff edcba987 0
1 06 3 01018181 00010203 01020408 0
1 07 2 80008000 00040011 08004000 0
1 08 3 80407fff 01020307 c0100fff 0
1 08 0 80000000 00000024 f8000000 0
1 09 0 12345678 00000008 78123456 0
0 00 0 00000000 00000000 00000000 0
1 0a 2 12345678 12345679 ffff0000 1
1 0c 3 7f80017f 80017f7f ff000000 1
1 0d 3 7f80017f 80017f7f 00ff0000 0
1 10 0 ffffffff 00000001 ffffffff 1
1 13 0 ffffffff 00000001 00000000 0
1 0e 2 8000ffff 7fffffff 0000ffff 0
1 14 0 80000000 00000001 00000001 1
1 15 0 80000000 00000001 00000000 0
1 16 3 7f80017f 80017f7e 8080017e 0
1 19 2 80000001 7fff0002 80000002 0
0 00 0 00000000 00000000 00000000 0
1 1a 0 00100000 00000000 00000014 0
1 1a 0 00000000 00000000 00000020 0
1 1b 0 00100000 00000000 0000000b 0
1 1c 0 f0f00001 00000000 00000009 0
1 1d 0 00000000 00000000 00000000 0
1 1d 0 ffffffff 00000000 0000001f 0
1 1d 0 fff00000 00000000 0000000b 0

/* files.f */
design/alu_pkg.sv
design/alu_find_first.sv
design/alu_adder.sv
design/alu_shifter.sv
design/alu_compare.sv
design/alu_bitcount.sv
design/alu_result_stage.sv
design/alu_top.sv
dv/alu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module alu_tb -o alu_sim
./obj_dir/alu_sim | tee sim.log

if grep -q "^Simulation PASSED$" sim.log; then
  exit 0
fi
exit 1
